/* hdl/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int MASK_W     = 4;   // bytes per word
    localparam int LINE_W     = 256;
    localparam int BURST_W    = 64;  // physical bus beat
    localparam int BEATS      = 4;   // beats per line
    localparam int OFFSET_W   = 5;
    localparam int IC_INDEX_W = 3;   // 8 sets
    localparam int DC_INDEX_W = 3;   // 8 sets x 2 ways

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [MASK_W-1:0]  mask_t;
    typedef logic [LINE_W-1:0]  line_t;
    typedef logic [BURST_W-1:0] burst_t;

    // both caches use the same index width, so one tag type fits both
    typedef logic [ADDR_W-OFFSET_W-IC_INDEX_W-1:0] tag_t;

    typedef enum logic {
        IC_IDLE,
        IC_FILL
    } icache_state_t;

    typedef enum logic [1:0] {
        DC_IDLE,
        DC_WRITEBACK,
        DC_FILL
    } dcache_state_t;

    typedef enum logic [1:0] {
        AD_IDLE,
        AD_READ,
        AD_WRITE,
        AD_DONE
    } adaptor_state_t;

    typedef enum logic [1:0] {
        ARB_NONE,
        ARB_I,
        ARB_D
    } arb_owner_t;

endpackage

`default_nettype wire

/* hdl/line_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface line_bus_if;

    mem_pkg::addr_t address;   // line aligned
    logic           read;
    logic           write;
    mem_pkg::line_t wdata;
    mem_pkg::line_t rdata;     // valid with resp
    logic           resp;      // one cycle pulse

    modport master (
        output address, read, write, wdata,
        input  rdata, resp
    );

    modport slave (
        input  address, read, write, wdata,
        output rdata, resp
    );

endinterface

`default_nettype wire

/* hdl/icache.sv */
`timescale 1ns/1ps
`default_nettype none

module icache (
    input  logic           clk,
    input  logic           rst,
    input  mem_pkg::addr_t imem_addr_i,
    input  logic           imem_read_i,
    output mem_pkg::word_t imem_rdata_o,
    output logic           imem_resp_o,
    line_bus_if.master     line
);

    mem_pkg::icache_state_t state;

    mem_pkg::line_t data_q [2**mem_pkg::IC_INDEX_W];
    mem_pkg::tag_t  tag_q  [2**mem_pkg::IC_INDEX_W];
    logic [2**mem_pkg::IC_INDEX_W-1:0] valid_q;

    logic [mem_pkg::IC_INDEX_W-1:0] idx;
    mem_pkg::tag_t                  tag;
    logic [mem_pkg::OFFSET_W-3:0]   word_sel;
    logic                           hit;
    logic                           access;

    assign idx      = imem_addr_i[mem_pkg::OFFSET_W +: mem_pkg::IC_INDEX_W];
    assign tag      = imem_addr_i[mem_pkg::ADDR_W-1:mem_pkg::OFFSET_W+mem_pkg::IC_INDEX_W];
    assign word_sel = imem_addr_i[mem_pkg::OFFSET_W-1:2];
    assign hit      = valid_q[idx] && (tag_q[idx] == tag);

    // request still held in the resp cycle is the old one, skip it
    assign access = (state == mem_pkg::IC_IDLE) && imem_read_i && !imem_resp_o;

    assign line.read    = (state == mem_pkg::IC_FILL);
    assign line.write   = 1'b0;                     // read only
    assign line.wdata   = '0;
    assign line.address = {tag, idx, {mem_pkg::OFFSET_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= mem_pkg::IC_IDLE;
            imem_resp_o <= 1'b0;
            valid_q     <= '0;
        end else begin
            imem_resp_o <= 1'b0;
            case (state)
                mem_pkg::IC_IDLE: begin
                    if (access && hit) begin
                        imem_resp_o <= 1'b1;
                    end else if (access) begin
                        state <= mem_pkg::IC_FILL;
                    end
                end
                mem_pkg::IC_FILL: begin
                    if (line.resp) begin
                        valid_q[idx] <= 1'b1;
                        state        <= mem_pkg::IC_IDLE;   // answered as a hit next
                    end
                end
                default: state <= mem_pkg::IC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        imem_rdata_o <= data_q[idx][word_sel*mem_pkg::WORD_W +: mem_pkg::WORD_W];
        if (state == mem_pkg::IC_FILL && line.resp) begin
            data_q[idx] <= line.rdata;
            tag_q[idx]  <= tag;
        end
    end

endmodule

`default_nettype wire

/* hdl/dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache (
    input  logic           clk,
    input  logic           rst,
    input  mem_pkg::addr_t dmem_addr_i,
    input  logic           dmem_read_i,
    input  logic           dmem_write_i,
    input  mem_pkg::mask_t dmem_wmask_i,
    input  mem_pkg::word_t dmem_wdata_i,
    output mem_pkg::word_t dmem_rdata_o,
    output logic           dmem_resp_o,
    line_bus_if.master     line
);

    mem_pkg::dcache_state_t state;

    mem_pkg::line_t data_q [2][2**mem_pkg::DC_INDEX_W];
    mem_pkg::tag_t  tag_q  [2][2**mem_pkg::DC_INDEX_W];
    logic [2**mem_pkg::DC_INDEX_W-1:0] valid_q [2];
    logic [2**mem_pkg::DC_INDEX_W-1:0] dirty_q [2];
    logic [2**mem_pkg::DC_INDEX_W-1:0] lru_q;           // way not most recently used

    logic [mem_pkg::DC_INDEX_W-1:0] idx;
    mem_pkg::tag_t                  tag;
    logic [mem_pkg::OFFSET_W-3:0]   word_sel;
    logic                           hit0;
    logic                           hit1;
    logic                           hit;
    logic                           hit_way;
    logic                           victim;
    logic                           access;
    mem_pkg::line_t                 hit_line;
    mem_pkg::line_t                 merged_line;

    assign idx      = dmem_addr_i[mem_pkg::OFFSET_W +: mem_pkg::DC_INDEX_W];
    assign tag      = dmem_addr_i[mem_pkg::ADDR_W-1:mem_pkg::OFFSET_W+mem_pkg::DC_INDEX_W];
    assign word_sel = dmem_addr_i[mem_pkg::OFFSET_W-1:2];

    assign hit0     = valid_q[0][idx] && (tag_q[0][idx] == tag);
    assign hit1     = valid_q[1][idx] && (tag_q[1][idx] == tag);
    assign hit      = hit0 || hit1;
    assign hit_way  = hit1;
    assign victim   = lru_q[idx];                 // stable for the whole miss
    assign hit_line = data_q[hit_way][idx];

    assign access = (state == mem_pkg::DC_IDLE) && (dmem_read_i || dmem_write_i)
                    && !dmem_resp_o;

    // byte lanes of the addressed word replaced where the mask is set
    always_comb begin
        merged_line = hit_line;
        for (int k = 0; k < mem_pkg::MASK_W; k++) begin
            if (dmem_wmask_i[k]) begin
                merged_line[word_sel*mem_pkg::WORD_W + k*8 +: 8] = dmem_wdata_i[k*8 +: 8];
            end
        end
    end

    assign line.read    = (state == mem_pkg::DC_FILL);
    assign line.write   = (state == mem_pkg::DC_WRITEBACK);
    assign line.wdata   = data_q[victim][idx];
    assign line.address = (state == mem_pkg::DC_WRITEBACK)
                          ? {tag_q[victim][idx], idx, {mem_pkg::OFFSET_W{1'b0}}}
                          : {tag, idx, {mem_pkg::OFFSET_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= mem_pkg::DC_IDLE;
            dmem_resp_o <= 1'b0;
            valid_q[0]  <= '0;
            valid_q[1]  <= '0;
            dirty_q[0]  <= '0;
            dirty_q[1]  <= '0;
            lru_q       <= '0;
        end else begin
            dmem_resp_o <= 1'b0;
            case (state)
                mem_pkg::DC_IDLE: begin
                    if (access && hit) begin
                        dmem_resp_o <= 1'b1;
                        lru_q[idx]  <= ~hit_way;
                        if (dmem_write_i) begin
                            dirty_q[hit_way][idx] <= 1'b1;
                        end
                    end else if (access && valid_q[victim][idx] && dirty_q[victim][idx]) begin
                        state <= mem_pkg::DC_WRITEBACK;
                    end else if (access) begin
                        state <= mem_pkg::DC_FILL;
                    end
                end
                mem_pkg::DC_WRITEBACK: begin
                    if (line.resp) begin
                        dirty_q[victim][idx] <= 1'b0;
                        state                <= mem_pkg::DC_FILL;
                    end
                end
                mem_pkg::DC_FILL: begin
                    if (line.resp) begin
                        valid_q[victim][idx] <= 1'b1;
                        dirty_q[victim][idx] <= 1'b0;
                        state                <= mem_pkg::DC_IDLE;   // retried as a hit
                    end
                end
                default: state <= mem_pkg::DC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        dmem_rdata_o <= hit_line[word_sel*mem_pkg::WORD_W +: mem_pkg::WORD_W];
        if (access && hit && dmem_write_i) begin
            data_q[hit_way][idx] <= merged_line;
        end else if (state == mem_pkg::DC_FILL && line.resp) begin
            data_q[victim][idx] <= line.rdata;
            tag_q[victim][idx]  <= tag;
        end
    end

endmodule

`default_nettype wire

/* hdl/line_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module line_arbiter (
    input  logic      clk,
    input  logic      rst,
    line_bus_if.slave ic,
    line_bus_if.slave dc,
    line_bus_if.master mem
);

    mem_pkg::arb_owner_t owner_q;
    mem_pkg::arb_owner_t grant;
    logic                sel_i;
    logic                sel_d;

    // an idle bus goes to data first, a held owner keeps it
    always_comb begin
        grant = owner_q;
        if (owner_q == mem_pkg::ARB_NONE) begin
            if (dc.read || dc.write) begin
                grant = mem_pkg::ARB_D;
            end else if (ic.read || ic.write) begin
                grant = mem_pkg::ARB_I;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            owner_q <= mem_pkg::ARB_NONE;
        end else if (mem.resp) begin
            owner_q <= mem_pkg::ARB_NONE;   // release after the transfer
        end else begin
            owner_q <= grant;
        end
    end

    assign sel_i = (grant == mem_pkg::ARB_I);
    assign sel_d = (grant == mem_pkg::ARB_D);

    assign mem.address = sel_d ? dc.address : ic.address;
    assign mem.wdata   = sel_d ? dc.wdata : ic.wdata;
    assign mem.read    = sel_d ? dc.read : (sel_i && ic.read);
    assign mem.write   = sel_d ? dc.write : (sel_i && ic.write);

    assign ic.rdata = mem.rdata;
    assign dc.rdata = mem.rdata;
    assign ic.resp  = sel_i && mem.resp;   // owner only
    assign dc.resp  = sel_d && mem.resp;

endmodule

`default_nettype wire

/* hdl/cacheline_adaptor.sv */
`timescale 1ns/1ps
`default_nettype none

module cacheline_adaptor (
    input  logic            clk,
    input  logic            rst,
    line_bus_if.slave       line,
    output mem_pkg::addr_t  bmem_addr_o,
    output logic            bmem_read_o,
    output logic            bmem_write_o,
    output mem_pkg::burst_t bmem_wdata_o,
    input  mem_pkg::burst_t bmem_rdata_i,
    input  logic            bmem_resp_i
);

    mem_pkg::adaptor_state_t state;

    logic [$clog2(mem_pkg::BEATS)-1:0] cnt;   // current beat
    mem_pkg::addr_t                    addr_q;
    mem_pkg::line_t                    buf_q;
    logic                              last_beat;

    assign last_beat = bmem_resp_i && (cnt == ($clog2(mem_pkg::BEATS))'(mem_pkg::BEATS - 1));

    // strobe held until the first beat, the rest follow back to back
    assign bmem_read_o  = (state == mem_pkg::AD_READ) && (cnt == '0);
    assign bmem_write_o = (state == mem_pkg::AD_WRITE) && (cnt == '0);
    assign bmem_wdata_o = buf_q[cnt*mem_pkg::BURST_W +: mem_pkg::BURST_W];
    assign bmem_addr_o  = addr_q;

    assign line.rdata = buf_q;
    assign line.resp  = (state == mem_pkg::AD_DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mem_pkg::AD_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                mem_pkg::AD_IDLE: begin
                    cnt <= '0;
                    if (line.read) begin
                        state <= mem_pkg::AD_READ;
                    end else if (line.write) begin
                        state <= mem_pkg::AD_WRITE;
                    end
                end
                mem_pkg::AD_READ, mem_pkg::AD_WRITE: begin
                    if (bmem_resp_i) begin
                        cnt <= cnt + 1'b1;
                    end
                    if (last_beat) begin
                        state <= mem_pkg::AD_DONE;
                    end
                end
                mem_pkg::AD_DONE: state <= mem_pkg::AD_IDLE;   // request still up, ignore it
                default:          state <= mem_pkg::AD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mem_pkg::AD_IDLE) begin
            addr_q <= {line.address[mem_pkg::ADDR_W-1:mem_pkg::OFFSET_W],
                       {mem_pkg::OFFSET_W{1'b0}}};
            buf_q  <= line.wdata;                // write data, overwritten on reads
        end else if (state == mem_pkg::AD_READ && bmem_resp_i) begin
            buf_q[cnt*mem_pkg::BURST_W +: mem_pkg::BURST_W] <= bmem_rdata_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/mem_hier.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_hier (
    input  logic            clk,
    input  logic            rst,
    // instruction side
    input  mem_pkg::addr_t  imem_addr_i,
    input  logic            imem_read_i,
    output mem_pkg::word_t  imem_rdata_o,
    output logic            imem_resp_o,
    // data side
    input  mem_pkg::addr_t  dmem_addr_i,
    input  logic            dmem_read_i,
    input  logic            dmem_write_i,
    input  mem_pkg::mask_t  dmem_wmask_i,
    input  mem_pkg::word_t  dmem_wdata_i,
    output mem_pkg::word_t  dmem_rdata_o,
    output logic            dmem_resp_o,
    // physical memory
    output mem_pkg::addr_t  bmem_addr_o,
    output logic            bmem_read_o,
    output logic            bmem_write_o,
    output mem_pkg::burst_t bmem_wdata_o,
    input  mem_pkg::burst_t bmem_rdata_i,
    input  logic            bmem_resp_i
);

    line_bus_if ic_line ();    // icache -> arbiter
    line_bus_if dc_line ();    // dcache -> arbiter
    line_bus_if mem_line ();   // arbiter -> adaptor

    icache icache0 (
        .clk, .rst,
        .imem_addr_i, .imem_read_i, .imem_rdata_o, .imem_resp_o,
        .line (ic_line)
    );

    dcache dcache0 (
        .clk, .rst,
        .dmem_addr_i, .dmem_read_i, .dmem_write_i, .dmem_wmask_i,
        .dmem_wdata_i, .dmem_rdata_o, .dmem_resp_o,
        .line (dc_line)
    );

    line_arbiter line_arbiter0 (
        .clk, .rst,
        .ic  (ic_line),
        .dc  (dc_line),
        .mem (mem_line)
    );

    cacheline_adaptor cacheline_adaptor0 (
        .clk, .rst,
        .line (mem_line),
        .bmem_addr_o, .bmem_read_o, .bmem_write_o,
        .bmem_wdata_o, .bmem_rdata_i, .bmem_resp_i
    );

endmodule

`default_nettype wire

/* bench/mem_hier_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_hier_assertions (
    input logic           clk,
    input logic           rst,
    input mem_pkg::addr_t imem_addr_i,
    input logic           imem_read_i,
    input logic           imem_resp_i,
    input mem_pkg::addr_t dmem_addr_i,
    input logic           dmem_req_i,      // read or write
    input logic           dmem_resp_i,
    input logic           bmem_read_i,
    input logic           bmem_write_i,
    input logic           bmem_resp_i,
    input mem_pkg::addr_t line_addr_i,
    input logic           line_read_i,
    input logic           line_write_i,
    input mem_pkg::line_t line_wdata_i,
    input logic           line_resp_i
);

    logic [mem_pkg::ADDR_W-mem_pkg::OFFSET_W-1:0] i_line_q;
    logic [mem_pkg::ADDR_W-mem_pkg::OFFSET_W-1:0] d_line_q;
    logic       i_seen_q;
    logic       d_seen_q;
    logic       i_req_q;
    logic       d_req_q;
    logic [2:0] beats_q;      // beats since the last line resp
    logic       i_repeat;
    logic       d_repeat;

    // new request to the line of the previous completed access on that side
    assign i_repeat = imem_read_i && !i_req_q && i_seen_q
                      && (imem_addr_i[mem_pkg::ADDR_W-1:mem_pkg::OFFSET_W] == i_line_q);
    assign d_repeat = dmem_req_i && !d_req_q && d_seen_q
                      && (dmem_addr_i[mem_pkg::ADDR_W-1:mem_pkg::OFFSET_W] == d_line_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            i_seen_q <= 1'b0;
            d_seen_q <= 1'b0;
            i_req_q  <= 1'b0;
            d_req_q  <= 1'b0;
            beats_q  <= '0;
        end else begin
            i_req_q <= imem_read_i;
            d_req_q <= dmem_req_i;
            if (imem_resp_i) begin
                i_seen_q <= 1'b1;
                i_line_q <= imem_addr_i[mem_pkg::ADDR_W-1:mem_pkg::OFFSET_W];
            end
            if (dmem_resp_i) begin
                d_seen_q <= 1'b1;
                d_line_q <= dmem_addr_i[mem_pkg::ADDR_W-1:mem_pkg::OFFSET_W];
            end
            if (line_resp_i) begin
                beats_q <= '0;
            end else if (bmem_resp_i) begin
                beats_q <= beats_q + 3'd1;
            end
        end
    end

    quiet_after_reset: assert property (@(posedge clk)
        rst |=> !imem_resp_i && !dmem_resp_i && !line_read_i && !line_write_i
                && !bmem_read_i && !bmem_write_i)
        else $error("strobe or resp active during reset");

    read_held: assert property (@(posedge clk) disable iff (rst)
        (line_read_i && !line_resp_i) |=> line_read_i && $stable(line_addr_i))
        else $error("line read dropped or changed before resp");

    write_held: assert property (@(posedge clk) disable iff (rst)
        (line_write_i && !line_resp_i) |=>
            line_write_i && $stable(line_addr_i) && $stable(line_wdata_i))
        else $error("line write dropped or changed before resp");

    bmem_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(bmem_read_i && bmem_write_i))
        else $error("bmem read and write both high");

    imem_resp_pulse: assert property (@(posedge clk) disable iff (rst)
        imem_resp_i |=> !imem_resp_i)
        else $error("imem resp longer than one cycle");

    dmem_resp_pulse: assert property (@(posedge clk) disable iff (rst)
        dmem_resp_i |=> !dmem_resp_i)
        else $error("dmem resp longer than one cycle");

    line_resp_pulse: assert property (@(posedge clk) disable iff (rst)
        line_resp_i |=> !line_resp_i)
        else $error("line resp longer than one cycle");

    four_beats: assert property (@(posedge clk) disable iff (rst)
        line_resp_i |-> (beats_q == 3'd4))
        else $error("line transfer did not take four beats");

    imem_hit_latency: assert property (@(posedge clk) disable iff (rst)
        i_repeat |=> imem_resp_i)
        else $error("repeat fetch to a present line did not hit");

    dmem_hit_latency: assert property (@(posedge clk) disable iff (rst)
        d_repeat |=> dmem_resp_i)
        else $error("repeat data access to a present line did not hit");

endmodule

bind mem_hier mem_hier_assertions chk0 (
    .clk          (clk),
    .rst          (rst),
    .imem_addr_i  (imem_addr_i),
    .imem_read_i  (imem_read_i),
    .imem_resp_i  (imem_resp_o),
    .dmem_addr_i  (dmem_addr_i),
    .dmem_req_i   (dmem_read_i || dmem_write_i),
    .dmem_resp_i  (dmem_resp_o),
    .bmem_read_i  (bmem_read_o),
    .bmem_write_i (bmem_write_o),
    .bmem_resp_i  (bmem_resp_i),
    .line_addr_i  (mem_line.address),
    .line_read_i  (mem_line.read),
    .line_write_i (mem_line.write),
    .line_wdata_i (mem_line.wdata),
    .line_resp_i  (mem_line.resp)
);

`default_nettype wire

/* bench/tb_mem_hier.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_hier;

    localparam int CLK_NS    = 40;
    localparam int N_LINES   = 64;            // model size, 2 KB
    localparam int N_RANDOM  = 200;
    localparam int N_ACCESS  = N_RANDOM + 40;  // directed accesses included
    localparam int CODE_BASE = 32;            // fetch region, data never writes here

    logic            clk;
    logic            rst;
    mem_pkg::addr_t  imem_addr;
    logic            imem_read;
    mem_pkg::word_t  imem_rdata;
    logic            imem_resp;
    mem_pkg::addr_t  dmem_addr;
    logic            dmem_read;
    logic            dmem_write;
    mem_pkg::mask_t  dmem_wmask;
    mem_pkg::word_t  dmem_wdata;
    mem_pkg::word_t  dmem_rdata;
    logic            dmem_resp;
    mem_pkg::addr_t  bmem_addr;
    logic            bmem_read;
    logic            bmem_write;
    mem_pkg::burst_t bmem_wdata;
    mem_pkg::burst_t bmem_rdata;
    logic            bmem_resp;

    mem_pkg::line_t mem_q [N_LINES];
    mem_pkg::word_t init_words [N_LINES*8];   // fetch expectations
    mem_pkg::word_t shadow [N_LINES*8];       // data expectations
    integer         seed = 11085;

    mem_hier dut0 (
        .clk          (clk),
        .rst          (rst),
        .imem_addr_i  (imem_addr),
        .imem_read_i  (imem_read),
        .imem_rdata_o (imem_rdata),
        .imem_resp_o  (imem_resp),
        .dmem_addr_i  (dmem_addr),
        .dmem_read_i  (dmem_read),
        .dmem_write_i (dmem_write),
        .dmem_wmask_i (dmem_wmask),
        .dmem_wdata_i (dmem_wdata),
        .dmem_rdata_o (dmem_rdata),
        .dmem_resp_o  (dmem_resp),
        .bmem_addr_o  (bmem_addr),
        .bmem_read_o  (bmem_read),
        .bmem_write_o (bmem_write),
        .bmem_wdata_o (bmem_wdata),
        .bmem_rdata_i (bmem_rdata),
        .bmem_resp_i  (bmem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS/2) clk = ~clk;
    end

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string sig, input mem_pkg::word_t exp,
                              input mem_pkg::word_t got);
        assert (got === exp) else begin
            $display("FAIL %0t %s expected %h actual %h", $time, sig, exp, got);
            fail_now("read data does not match the expected word");
        end
    endtask

    task automatic expect_hit(input string sig, input int lat);
        assert (lat == 2) else begin
            $display("FAIL %0t %s latency expected 2 actual %0d", $time, sig, lat);
            fail_now("access to a present line did not hit");
        end
    endtask

    function automatic mem_pkg::addr_t addr_of(input int line_n, input int word_n);
        return mem_pkg::addr_t'(line_n * 32 + word_n * 4);
    endfunction

    task automatic fetch(input int line_n, input int word_n, output int lat);
        @(posedge clk);
        imem_addr <= addr_of(line_n, word_n);
        imem_read <= 1'b1;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!imem_resp);
        check_word("imem_rdata_o", init_words[line_n*8 + word_n], imem_rdata);
        @(posedge clk);
        imem_read <= 1'b0;
    endtask

    task automatic data_access(input int line_n, input int word_n, input logic is_wr,
                               input mem_pkg::mask_t mask, input mem_pkg::word_t wdata,
                               output int lat);
        int i;
        i = line_n * 8 + word_n;
        @(posedge clk);
        dmem_addr  <= addr_of(line_n, word_n);
        dmem_read  <= !is_wr;
        dmem_write <= is_wr;
        dmem_wmask <= mask;
        dmem_wdata <= wdata;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!dmem_resp);
        if (is_wr) begin
            for (int k = 0; k < mem_pkg::MASK_W; k++) begin
                if (mask[k]) begin
                    shadow[i][k*8 +: 8] = wdata[k*8 +: 8];   // byte merge
                end
            end
        end else begin
            check_word("dmem_rdata_o", shadow[i], dmem_rdata);
        end
        @(posedge clk);
        dmem_read  <= 1'b0;
        dmem_write <= 1'b0;
    endtask

    task automatic data_read(input int line_n, input int word_n, output int lat);
        data_access(line_n, word_n, 1'b0, 4'h0, '0, lat);
    endtask

    task automatic data_write(input int line_n, input int word_n,
                              input mem_pkg::mask_t mask, input mem_pkg::word_t wdata);
        int lat;
        data_access(line_n, word_n, 1'b1, mask, wdata, lat);
    endtask

    // burst memory, 0..3 wait cycles then four beats back to back
    initial begin : burst_memory
        int   line_idx;
        int   wait_n;
        logic is_wr;
        logic addr_ok;
        forever begin
            @(negedge clk);
            if (!rst && (bmem_read || bmem_write)) begin
                is_wr    = bmem_write;
                addr_ok  = (bmem_addr[mem_pkg::OFFSET_W-1:0] == '0)
                           && (bmem_addr < N_LINES * 32);
                assert (addr_ok) else begin
                    fail_now("burst address is not a line-aligned address inside the model");
                end
                line_idx = int'(bmem_addr[10:5]);
                wait_n   = $unsigned($random(seed)) % 4;
                repeat (wait_n) @(posedge clk);
                for (int b = 0; b < mem_pkg::BEATS; b++) begin
                    @(posedge clk);
                    bmem_resp  <= 1'b1;
                    bmem_rdata <= mem_q[line_idx][b*mem_pkg::BURST_W +: mem_pkg::BURST_W];
                    @(negedge clk);
                    if (is_wr) begin
                        mem_q[line_idx][b*mem_pkg::BURST_W +: mem_pkg::BURST_W] = bmem_wdata;
                    end
                end
                @(posedge clk);
                bmem_resp <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (N_ACCESS * 60 + 200) @(posedge clk);
        fail_now("watchdog expired before the tests finished");
    end

    initial begin
        int lat;
        int lat_i;
        int lat_d;
        int kind;
        int line_n;
        int word_n;
        rst        <= 1'b1;
        imem_addr  <= '0;
        imem_read  <= 1'b0;
        dmem_addr  <= '0;
        dmem_read  <= 1'b0;
        dmem_write <= 1'b0;
        dmem_wmask <= '0;
        dmem_wdata <= '0;
        bmem_rdata <= '0;
        bmem_resp  <= 1'b0;
        for (int i = 0; i < N_LINES * 8; i++) begin
            init_words[i] = $random(seed);
            shadow[i]     = init_words[i];
            mem_q[i/8][(i%8)*32 +: 32] = init_words[i];
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // cold fetches, then a repeat to each line
        for (int l = 0; l < 4; l++) begin
            fetch(CODE_BASE + l, l, lat);
            fetch(CODE_BASE + l, 7 - l, lat);
            expect_hit("imem_resp_o", lat);
        end

        // read miss, masked writes, read back merged bytes
        for (int l = 0; l < 4; l++) begin
            data_read(l, 3, lat);
            data_write(l, 3, 4'b0101, $random(seed));
            data_write(l, 3, 4'b1000, $random(seed));
            data_read(l, 3, lat);
            expect_hit("dmem_resp_o", lat);
        end

        // lines 5, 13 and 21 share set 5
        data_write(5, 0, 4'hf, $random(seed));
        data_write(13, 1, 4'hf, $random(seed));
        data_read(5, 0, lat);                      // 13 becomes LRU
        data_write(21, 2, 4'hf, $random(seed));    // dirty eviction of 13
        data_read(5, 0, lat);
        expect_hit("dmem_resp_o", lat);
        data_read(13, 1, lat);
        data_read(21, 2, lat);
        data_read(5, 0, lat);

        // both caches miss on the same edge
        fork
            fetch(CODE_BASE + 8, 1, lat_i);
            data_read(6, 2, lat_d);
        join
        assert (lat_d < lat_i) else begin
            fail_now("instruction miss was served before the data miss");
        end

        for (int n = 0; n < N_RANDOM; n++) begin
            kind   = $unsigned($random(seed)) % 3;
            line_n = $unsigned($random(seed)) % 16;
            word_n = $unsigned($random(seed)) % 8;
            case (kind)
                0:       fetch(CODE_BASE + line_n, word_n, lat);
                1:       data_read(line_n, word_n, lat);
                default: data_write(line_n, word_n, mem_pkg::mask_t'($random(seed)),
                                    $random(seed));
            endcase
        end

        repeat (2) @(posedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
hdl/mem_pkg.sv
hdl/line_bus_if.sv
hdl/icache.sv
hdl/dcache.sv
hdl/line_arbiter.sv
hdl/cacheline_adaptor.sv
hdl/mem_hier.sv
bench/mem_hier_assertions.sv
bench/tb_mem_hier.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --top-module tb_mem_hier -f files.f -o tb_sim > sim.log 2>&1 \
    && ./obj_dir/tb_sim >> sim.log 2>&1 \
    || echo "SIMULATION FAILED" >> sim.log

cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0
